// File: sources.f
+incdir+hw
hw/cpu_pkg.sv
hw/pipe_reg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
test/tb_cpu_top.sv

// File: run.sh
#!/bin/sh
# build the cpu testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps --top-module tb_cpu_top \
        -f sources.f -o tb_cpu_top &&
./obj_dir/tb_cpu_top | tee /dev/stderr | grep "TEST OK" > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: test/tb_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module tb_cpu_top;

        localparam logic [31:0] SEED       = 32'haf7c14cf;
        localparam int          MAX_CYCLES = 3000;      // 5 progs x 40 instr x 4 cycles, + load/drain
        localparam logic [5:0]  OP_ADDI = 6'h08;
        localparam logic [5:0]  OP_LW   = 6'h23;
        localparam logic [5:0]  OP_SW   = 6'h2b;
        localparam logic [5:0]  OP_BEQ  = 6'h04;
        localparam logic [5:0]  OP_J    = 6'h02;
        localparam logic [5:0]  FN_ADD  = 6'h20;
        localparam logic [5:0]  FN_SUB  = 6'h22;
        localparam logic [5:0]  FN_AND  = 6'h24;
        localparam logic [5:0]  FN_OR   = 6'h25;
        localparam logic [5:0]  FN_SLT  = 6'h2a;
        localparam logic [15:0] IO_OFS  = 16'h8000;     // bit 15 set, base r0

        logic                   clk;
        logic                   rst_n;
        logic                   run;
        logic                   prog_we;
        logic [`IMEM_AW-1:0]    prog_addr;
        logic [`XLEN-1:0]       prog_data;
        logic                   io_write;
        logic [`XLEN-1:0]       io_data;

        logic [31:0]            prog_q[$];              // program image
        logic [31:0]            exp_q[$];               // expected io words, in order
        logic [31:0]            io_q[$];                // io words seen
        int                     value_errors = 0;
        int                     event_errors = 0;
        int                     cycles = 0;
        int unsigned            seed_val;

        cpu_top i_cpu_top (
                .clk(clk), .rst_n(rst_n), .run(run),
                .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
                .io_write(io_write), .io_data(io_data)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // global limit on run length
        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        // io port monitor, strobe must stay quiet while idle
        always @(posedge clk) begin
                if (io_write) begin
                        if (run) begin
                                io_q.push_back(io_data);
                        end else begin
                                $display("io_write went high at %0t while the core was idle", $time);
                                event_errors++;
                        end
                end
        end

        // mips field packing
        function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rd,
                                                   input logic [4:0] rs, input logic [4:0] rt);
                return {6'h00, rs, rt, rd, 5'd0, fn};
        endfunction

        function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                                   input logic [4:0] rs, input logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic logic [31:0] jump_word(input logic [25:0] target);  // word index
                return {OP_J, target};
        endfunction

        function automatic logic [31:0] io_store_word(input logic [4:0] rt);
                return itype_word(OP_SW, rt, 5'd0, IO_OFS);
        endfunction

        function automatic logic [31:0] sext16(input logic [15:0] imm);
                return {{16{imm[15]}}, imm};
        endfunction

        function automatic logic [31:0] signed_less(input logic [31:0] x, input logic [31:0] y);
                return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        endfunction

        // ends every program, keeps fetch off unwritten words
        task automatic add_self_loop();
                prog_q.push_back(jump_word(26'(prog_q.size())));
        endtask

        task automatic load_program();
                run = 1'b0;
                for (int i = 0; i < prog_q.size(); i++) begin
                        @(posedge clk);
                        #1;
                        prog_we   = 1'b1;
                        prog_addr = 8'(i);
                        prog_data = prog_q[i];
                end
                @(posedge clk);
                #1;
                prog_we = 1'b0;
        endtask

        task automatic run_program();
                io_q.delete();
                @(posedge clk);
                #1;
                run = 1'b1;
                while (io_q.size() < exp_q.size())
                        @(posedge clk);         // timeout covers a lost store
                repeat (10) @(posedge clk);     // window for extra stores
                #1;
                run = 1'b0;
                repeat (6) @(posedge clk);      // in-flight loop drains
        endtask

        task automatic check_results(input string name);
                int n;
                n = (io_q.size() < exp_q.size()) ? io_q.size() : exp_q.size();
                for (int i = 0; i < n; i++) begin
                        if (io_q[i] !== exp_q[i]) begin
                                $display("Error at %0t: %s io_data[%0d] = %h, expected %h",
                                         $time, name, i, io_q[i], exp_q[i]);
                                value_errors++;
                        end
                end
                if (io_q.size() != exp_q.size()) begin
                        $display("%s: %0d io writes seen where %0d were expected",
                                 name, io_q.size(), exp_q.size());
                        event_errors++;
                end
                prog_q.delete();
                exp_q.delete();
        endtask

        // mem and wb forwarding into both alu operands and store data
        task automatic forwarding_chain();
                logic [31:0] a, b, s, d, m, o;
                a = sext16(16'($urandom));
                b = sext16(16'($urandom));
                s = a + b;
                d = a - s;
                m = d & s;
                o = m | a;
                prog_q.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, a[15:0]));
                prog_q.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, b[15:0]));
                prog_q.push_back(rtype_word(FN_ADD, 5'd3, 5'd1, 5'd2));  // r2 mem, r1 wb
                prog_q.push_back(io_store_word(5'd3));
                prog_q.push_back(rtype_word(FN_SUB, 5'd4, 5'd1, 5'd3));  // r3 from wb
                prog_q.push_back(io_store_word(5'd4));
                prog_q.push_back(rtype_word(FN_AND, 5'd5, 5'd4, 5'd3));
                prog_q.push_back(rtype_word(FN_OR, 5'd6, 5'd5, 5'd1));
                prog_q.push_back(io_store_word(5'd5));
                prog_q.push_back(io_store_word(5'd6));
                add_self_loop();
                exp_q = '{s, d, m, o};
                load_program();
                run_program();
                check_results("forwarding");
        endtask

        task automatic load_use();
                logic [31:0] c;
                c = sext16(16'($urandom));
                prog_q.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, c[15:0]));
                prog_q.push_back(itype_word(OP_SW, 5'd1, 5'd0, 16'h0010));  // data memory
                prog_q.push_back(itype_word(OP_LW, 5'd2, 5'd0, 16'h0010));
                prog_q.push_back(itype_word(OP_ADDI, 5'd3, 5'd2, 16'd5));   // needs the bubble
                prog_q.push_back(io_store_word(5'd3));
                prog_q.push_back(rtype_word(FN_ADD, 5'd4, 5'd2, 5'd3));
                prog_q.push_back(io_store_word(5'd4));
                add_self_loop();
                exp_q = '{c + 32'd5, c + c + 32'd5};
                load_program();
                run_program();
                check_results("load-use");
        endtask

        task automatic branch_and_jump();
                prog_q.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd7));
                prog_q.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd7));
                prog_q.push_back(itype_word(OP_ADDI, 5'd3, 5'd0, 16'd9));
                prog_q.push_back(itype_word(OP_BEQ, 5'd2, 5'd1, 16'd1));    // taken, r2 in flight
                prog_q.push_back(io_store_word(5'd3));                      // skipped
                prog_q.push_back(io_store_word(5'd1));
                prog_q.push_back(itype_word(OP_BEQ, 5'd3, 5'd1, 16'd1));    // not taken
                prog_q.push_back(io_store_word(5'd3));
                prog_q.push_back(jump_word(26'd10));
                prog_q.push_back(io_store_word(5'd2));                      // skipped
                prog_q.push_back(itype_word(OP_ADDI, 5'd4, 5'd0, 16'd11));
                prog_q.push_back(io_store_word(5'd4));
                add_self_loop();
                exp_q = '{32'd7, 32'd9, 32'd11};
                load_program();
                run_program();
                check_results("branch");
        endtask

        task automatic signed_compare();
                logic [31:0] na, pa;
                na = sext16(16'hffff - {6'd0, 10'($urandom)});     // -1024 .. -1
                pa = {22'd0, 10'($urandom)};                        // 0 .. 1023
                prog_q.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, na[15:0]));
                prog_q.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, pa[15:0]));
                prog_q.push_back(rtype_word(FN_SLT, 5'd3, 5'd1, 5'd2));
                prog_q.push_back(rtype_word(FN_SLT, 5'd4, 5'd2, 5'd1));
                prog_q.push_back(itype_word(OP_ADDI, 5'd5, 5'd1, 16'hfffd)); // minus 3
                prog_q.push_back(rtype_word(FN_SLT, 5'd6, 5'd5, 5'd1));
                prog_q.push_back(io_store_word(5'd3));
                prog_q.push_back(io_store_word(5'd4));
                prog_q.push_back(io_store_word(5'd5));
                prog_q.push_back(io_store_word(5'd6));
                add_self_loop();
                exp_q = '{signed_less(na, pa), signed_less(pa, na), na + sext16(16'hfffd),
                          signed_less(na + sext16(16'hfffd), na)};
                load_program();
                run_program();
                check_results("signed");
        endtask

        // writes to r0 are dropped and never forwarded
        task automatic zero_register();
                logic [31:0] v;
                v = sext16(16'($urandom));
                prog_q.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, v[15:0]));
                prog_q.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, 16'd123));
                prog_q.push_back(io_store_word(5'd0));
                prog_q.push_back(rtype_word(FN_ADD, 5'd0, 5'd1, 5'd1));
                prog_q.push_back(io_store_word(5'd0));
                prog_q.push_back(io_store_word(5'd1));
                add_self_loop();
                exp_q = '{32'd0, 32'd0, v};
                load_program();
                run_program();
                check_results("r0");
        endtask

        initial begin
                rst_n     = 1'b0;
                run       = 1'b0;
                prog_we   = 1'b0;
                prog_addr = '0;
                prog_data = '0;
                seed_val  = $urandom(SEED);
                repeat (4) @(posedge clk);
                #1;
                rst_n = 1'b1;
                if (io_write !== 1'b0) begin            // strobe quiet out of reset
                        $display("Error at %0t: io_write = %b, expected 0", $time, io_write);
                        value_errors++;
                end
                forwarding_chain();
                load_use();
                branch_and_jump();
                signed_compare();
                zero_register();
                $display("%0d value errors, %0d event errors", value_errors, event_errors);
                if (value_errors == 0 && event_errors == 0)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module cpu_top (
        input  wire logic                       clk,
        input  wire logic                       rst_n,
        input  wire logic                       run,            // low = idle, load allowed
        input  wire logic                       prog_we,
        input  wire logic [`IMEM_AW-1:0]        prog_addr,
        input  wire logic [`XLEN-1:0]           prog_data,
        output logic                            io_write,
        output logic [`XLEN-1:0]                io_data
);

        cpu_pkg::if_id_t        if_d;           // fetch out
        cpu_pkg::if_id_t        if_q;           // decode in
        cpu_pkg::id_ex_t        id_d;
        cpu_pkg::id_ex_t        id_q;
        cpu_pkg::ex_mem_t       ex_d;
        cpu_pkg::ex_mem_t       ex_q;
        cpu_pkg::mem_wb_t       mem_d;
        cpu_pkg::mem_wb_t       mem_q;          // also the regfile write port
        logic                   stall;
        logic                   redirect;
        logic [`XLEN-1:0]       redirect_pc;

        fetch_stage u_fetch (
                .clk(clk), .rst_n(rst_n), .run(run),
                .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
                .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
                .if_out(if_d)
        );

        pipe_reg #(.payload_t(cpu_pkg::if_id_t)) u_if_id (
                .clk(clk), .rst_n(rst_n), .stall(stall), .flush(redirect), .d(if_d), .q(if_q)
        );

        decode_stage u_decode (
                .clk(clk), .rst_n(rst_n), .id_in(if_q),
                .ex_dest(id_q.dest), .mem_dest(ex_q.dest),
                .ex_reg_write(id_q.reg_write), .ex_mem_read(id_q.mem_read),
                .mem_reg_write(ex_q.reg_write), .wb_in(mem_q),
                .id_out(id_d), .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc)
        );

        // stall drops a bubble into execute
        pipe_reg #(.payload_t(cpu_pkg::id_ex_t)) u_id_ex (
                .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(stall), .d(id_d), .q(id_q)
        );

        execute_stage u_execute (
                .ex_in(id_q), .mem_fwd(ex_q), .wb_fwd(mem_q), .ex_out(ex_d)
        );

        pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) u_ex_mem (
                .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0), .d(ex_d), .q(ex_q)
        );

        memory_stage u_memory (
                .clk(clk), .rst_n(rst_n), .mem_in(ex_q),
                .mem_out(mem_d), .io_write(io_write), .io_data(io_data)
        );

        pipe_reg #(.payload_t(cpu_pkg::mem_wb_t)) u_mem_wb (
                .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0), .d(mem_d), .q(mem_q)
        );

endmodule

`default_nettype wire

// File: hw/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module memory_stage (
        input  wire logic               clk,
        input  wire logic               rst_n,
        input  wire cpu_pkg::ex_mem_t   mem_in,
        output cpu_pkg::mem_wb_t        mem_out,
        output logic                    io_write,       // one pulse per io store
        output logic [`XLEN-1:0]        io_data
);

        logic [`XLEN-1:0]       dmem [2**`DMEM_AW];
        logic [`DMEM_AW-1:0]    word_addr;
        logic                   is_io;
        logic                   dmem_we;
        logic                   io_hit;

        assign word_addr = mem_in.alu_res[`DMEM_AW+1:2];
        assign is_io     = mem_in.alu_res[`IO_ADDR_BIT];        // io window
        assign dmem_we   = mem_in.valid && mem_in.mem_write && !is_io;
        assign io_hit    = mem_in.valid && mem_in.mem_write && is_io;

        always_ff @(posedge clk) begin
                if (dmem_we)
                        dmem[word_addr] <= mem_in.store_data;
        end

        // output strobe
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        io_write <= 1'b0;
                else
                        io_write <= io_hit;
        end

        always_ff @(posedge clk) begin
                if (io_hit)
                        io_data <= mem_in.store_data;   // valid with io_write
        end

        always_comb begin
                mem_out.valid     = mem_in.valid;
                mem_out.reg_write = mem_in.reg_write;
                mem_out.wb_val    = mem_in.mem_read ? dmem[word_addr] : mem_in.alu_res;
                mem_out.dest      = mem_in.dest;
        end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module execute_stage (
        input  wire cpu_pkg::id_ex_t    ex_in,
        input  wire cpu_pkg::ex_mem_t   mem_fwd,        // ex/mem register output
        input  wire cpu_pkg::mem_wb_t   wb_fwd,         // mem/wb register output
        output cpu_pkg::ex_mem_t        ex_out
);

        cpu_pkg::fwd_sel_t      sel_a;
        cpu_pkg::fwd_sel_t      sel_b;
        logic [`XLEN-1:0]       op_a;
        logic [`XLEN-1:0]       rt_fwd;         // forwarded rt, also store data
        logic [`XLEN-1:0]       op_b;
        logic [`XLEN-1:0]       result;

        // newest producer wins, r0 never forwarded
        function automatic cpu_pkg::fwd_sel_t fwd_pick(input logic [`REG_ADDR_W-1:0] idx);
                if (idx != '0 && mem_fwd.valid && mem_fwd.reg_write && mem_fwd.dest == idx)
                        return cpu_pkg::FWD_MEM;
                if (idx != '0 && wb_fwd.valid && wb_fwd.reg_write && wb_fwd.dest == idx)
                        return cpu_pkg::FWD_WB;
                return cpu_pkg::FWD_REG;
        endfunction

        function automatic logic [`XLEN-1:0] fwd_mux(input cpu_pkg::fwd_sel_t sel,
                                                      input logic [`XLEN-1:0] reg_val);
                case (sel)
                        cpu_pkg::FWD_MEM: return mem_fwd.alu_res;
                        cpu_pkg::FWD_WB:  return wb_fwd.wb_val;
                        default:          return reg_val;
                endcase
        endfunction

        always_comb begin
                sel_a  = fwd_pick(ex_in.rs);
                sel_b  = fwd_pick(ex_in.rt);
                op_a   = fwd_mux(sel_a, ex_in.rs_val);
                rt_fwd = fwd_mux(sel_b, ex_in.rt_val);
                op_b   = ex_in.use_imm ? ex_in.imm : rt_fwd;
                case (ex_in.alu_op)
                        cpu_pkg::ALU_SUB: result = op_a - op_b;
                        cpu_pkg::ALU_AND: result = op_a & op_b;
                        cpu_pkg::ALU_OR:  result = op_a | op_b;
                        cpu_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                        default:          result = op_a + op_b;  // add, addi, address calc
                endcase
        end

        always_comb begin
                ex_out.valid      = ex_in.valid;
                ex_out.reg_write  = ex_in.reg_write;
                ex_out.mem_read   = ex_in.mem_read;
                ex_out.mem_write  = ex_in.mem_write;
                ex_out.alu_res    = result;
                ex_out.store_data = rt_fwd;
                ex_out.dest       = ex_in.dest;
        end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module decode_stage (
        input  wire logic                       clk,
        input  wire logic                       rst_n,
        input  wire cpu_pkg::if_id_t            id_in,
        input  wire logic [`REG_ADDR_W-1:0]     ex_dest,
        input  wire logic [`REG_ADDR_W-1:0]     mem_dest,
        input  wire logic                       ex_reg_write,
        input  wire logic                       ex_mem_read,
        input  wire logic                       mem_reg_write,
        input  wire cpu_pkg::mem_wb_t           wb_in,          // write port
        output cpu_pkg::id_ex_t                 id_out,
        output logic                            stall,
        output logic                            redirect,
        output logic [`XLEN-1:0]                redirect_pc
);

        logic [`XLEN-1:0]       regs [2**`REG_ADDR_W];
        cpu_pkg::opcode_t       opcode;
        cpu_pkg::funct_t        funct;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       simm;
        logic [`XLEN-1:0]       rs_val;
        logic [`XLEN-1:0]       rt_val;
        logic                   wb_we;
        cpu_pkg::alu_op_t       alu_op;
        logic                   use_imm;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   is_beq;
        logic                   is_j;
        logic                   use_rt;         // rt is a source
        logic                   load_use;
        logic                   branch_haz;

        // field split
        assign opcode = cpu_pkg::opcode_t'(id_in.instr[`OPCODE_MSB:`RS_MSB+1]);
        assign funct  = cpu_pkg::funct_t'(id_in.instr[`FUNCT_W-1:0]);
        assign rs     = id_in.instr[`RS_MSB -: `REG_ADDR_W];
        assign rt     = id_in.instr[`RT_MSB -: `REG_ADDR_W];
        assign rd     = id_in.instr[`RD_MSB -: `REG_ADDR_W];
        assign simm   = {{(`XLEN-`IMM_W){id_in.instr[`IMM_W-1]}}, id_in.instr[`IMM_W-1:0]};

        // register file, written in writeback
        assign wb_we = wb_in.valid && wb_in.reg_write && wb_in.dest != '0;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < 2**`REG_ADDR_W; i++)
                                regs[i] <= '0;
                end else if (wb_we) begin
                        regs[wb_in.dest] <= wb_in.wb_val;
                end
        end

        // r0 reads zero; same-cycle write goes straight through
        assign rs_val = (rs == '0) ? '0 : (wb_we && wb_in.dest == rs) ? wb_in.wb_val : regs[rs];
        assign rt_val = (rt == '0) ? '0 : (wb_we && wb_in.dest == rt) ? wb_in.wb_val : regs[rt];

        // control decode
        always_comb begin
                alu_op    = cpu_pkg::ALU_ADD;
                use_imm   = 1'b0;
                reg_write = 1'b0;
                mem_read  = 1'b0;
                mem_write = 1'b0;
                dest      = rt;                 // i type default
                is_beq    = 1'b0;
                is_j      = 1'b0;
                use_rt    = 1'b0;
                case (opcode)
                        cpu_pkg::OP_R: begin
                                reg_write = 1'b1;
                                dest      = rd;
                                use_rt    = 1'b1;
                                case (funct)
                                        cpu_pkg::F_ADD: alu_op = cpu_pkg::ALU_ADD;
                                        cpu_pkg::F_SUB: alu_op = cpu_pkg::ALU_SUB;
                                        cpu_pkg::F_AND: alu_op = cpu_pkg::ALU_AND;
                                        cpu_pkg::F_OR:  alu_op = cpu_pkg::ALU_OR;
                                        cpu_pkg::F_SLT: alu_op = cpu_pkg::ALU_SLT;
                                        default:        reg_write = 1'b0;  // unknown funct is a nop
                                endcase
                        end
                        cpu_pkg::OP_ADDI: begin
                                use_imm   = 1'b1;
                                reg_write = 1'b1;
                        end
                        cpu_pkg::OP_LW: begin
                                use_imm   = 1'b1;
                                reg_write = 1'b1;
                                mem_read  = 1'b1;
                        end
                        cpu_pkg::OP_SW: begin
                                use_imm   = 1'b1;
                                mem_write = 1'b1;
                                use_rt    = 1'b1;       // store data
                        end
                        cpu_pkg::OP_BEQ: begin
                                is_beq = 1'b1;
                                use_rt = 1'b1;
                        end
                        cpu_pkg::OP_J: is_j = 1'b1;
                        default: ;
                endcase
        end

        // hazards: loaded value not ready for ex, or beq source still in flight
        assign load_use = ex_mem_read && ex_dest != '0 &&
                          ((!is_j && ex_dest == rs) || (use_rt && ex_dest == rt));
        assign branch_haz = is_beq &&
                ((ex_reg_write && ex_dest != '0 && (ex_dest == rs || ex_dest == rt)) ||
                 (mem_reg_write && mem_dest != '0 && (mem_dest == rs || mem_dest == rt)));
        assign stall = id_in.valid && (load_use || branch_haz);

        // branch resolves here, no delay slot
        assign redirect    = id_in.valid && !stall && (is_j || (is_beq && rs_val == rt_val));
        assign redirect_pc = is_j ? {id_in.pc4[`XLEN-1:`RS_MSB+3], id_in.instr[`RS_MSB:0], 2'b00}
                                  : id_in.pc4 + {simm[`XLEN-3:0], 2'b00};

        always_comb begin
                id_out.valid     = id_in.valid;
                id_out.alu_op    = alu_op;
                id_out.use_imm   = use_imm;
                id_out.reg_write = reg_write && id_in.valid;
                id_out.mem_read  = mem_read && id_in.valid;
                id_out.mem_write = mem_write && id_in.valid;
                id_out.rs        = rs;
                id_out.rt        = rt;
                id_out.rs_val    = rs_val;
                id_out.rt_val    = rt_val;
                id_out.imm       = simm;
                id_out.dest      = dest;
        end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module fetch_stage (
        input  wire logic                       clk,
        input  wire logic                       rst_n,
        input  wire logic                       run,
        input  wire logic                       stall,
        input  wire logic                       redirect,
        input  wire logic [`XLEN-1:0]           redirect_pc,
        input  wire logic                       prog_we,
        input  wire logic [`IMEM_AW-1:0]        prog_addr,
        input  wire logic [`XLEN-1:0]           prog_data,
        output cpu_pkg::if_id_t                 if_out
);

        logic [`XLEN-1:0] imem [2**`IMEM_AW];   // program store
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] pc4;

        assign pc4 = pc + 'd4;

        // load port, only driven while run is low
        always_ff @(posedge clk) begin
                if (prog_we)
                        imem[prog_addr] <= prog_data;
        end

        // next pc select
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        pc <= '0;
                end else if (!run) begin
                        pc <= '0;               // parked at start while idle
                end else if (redirect) begin
                        pc <= redirect_pc;      // taken beq or j
                end else if (!stall) begin
                        pc <= pc4;
                end
        end

        always_comb begin
                if_out.valid = run;             // bubble while idle
                if_out.pc4   = pc4;
                if_out.instr = imem[pc[`IMEM_AW+1:2]];  // word index
        end

endmodule

`default_nettype wire

// File: hw/pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

// one stage register, payload is any packed struct with valid as a field
module pipe_reg #(
        parameter type payload_t = logic
) (
        input  wire logic       clk,
        input  wire logic       rst_n,
        input  wire logic       stall,          // hold current contents
        input  wire logic       flush,          // load a bubble
        input  wire payload_t   d,
        output payload_t        q
);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        q <= '0;
                end else if (flush) begin       // wins over stall
                        q <= '0;                // all zero, valid low
                end else if (!stall) begin
                        q <= d;
                end
        end

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none
`include "cpu_config.svh"

package cpu_pkg;

        // primary opcodes, mips encoding
        typedef enum logic [5:0] {
                OP_R    = 6'h00,
                OP_J    = 6'h02,
                OP_BEQ  = 6'h04,
                OP_ADDI = 6'h08,
                OP_LW   = 6'h23,
                OP_SW   = 6'h2b
        } opcode_t;

        // funct field of r type
        typedef enum logic [5:0] {
                F_ADD = 6'h20,
                F_SUB = 6'h22,
                F_AND = 6'h24,
                F_OR  = 6'h25,
                F_SLT = 6'h2a
        } funct_t;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_SLT
        } alu_op_t;

        // operand source in execute
        typedef enum logic [1:0] {
                FWD_REG,                // value read in decode
                FWD_MEM,                // result sitting in ex/mem
                FWD_WB                  // value being written back
        } fwd_sel_t;

        typedef struct packed {
                logic                   valid;
                logic [`XLEN-1:0]       pc4;
                logic [`XLEN-1:0]       instr;
        } if_id_t;

        typedef struct packed {
                logic                   valid;
                alu_op_t                alu_op;
                logic                   use_imm;        // operand b from imm
                logic                   reg_write;
                logic                   mem_read;
                logic                   mem_write;
                logic [`REG_ADDR_W-1:0] rs;
                logic [`REG_ADDR_W-1:0] rt;
                logic [`XLEN-1:0]       rs_val;
                logic [`XLEN-1:0]       rt_val;         // also store data
                logic [`XLEN-1:0]       imm;            // already sign extended
                logic [`REG_ADDR_W-1:0] dest;
        } id_ex_t;

        typedef struct packed {
                logic                   valid;
                logic                   reg_write;
                logic                   mem_read;
                logic                   mem_write;
                logic [`XLEN-1:0]       alu_res;        // address for lw/sw
                logic [`XLEN-1:0]       store_data;
                logic [`REG_ADDR_W-1:0] dest;
        } ex_mem_t;

        typedef struct packed {
                logic                   valid;
                logic                   reg_write;
                logic [`XLEN-1:0]       wb_val;
                logic [`REG_ADDR_W-1:0] dest;
        } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath
`define XLEN        32          // data and instruction width
`define REG_ADDR_W  5           // 32 gp registers

// memories, word addressed
`define IMEM_AW     8
`define DMEM_AW     8

`define IO_ADDR_BIT 15          // address bit that picks the output port

// instruction word layout
`define OPCODE_MSB  31          // opcode is [31:26]
`define RS_MSB      25          // also top bit of the j target
`define RT_MSB      20
`define RD_MSB      15
`define IMM_W       16
`define FUNCT_W     6

`endif
